/* spi_id_reader.f */
+incdir+hdl
hdl/spi_id_pkg.sv
hdl/spi_byte_engine.sv
hdl/spi_cs_framer.sv
hdl/devid_sequencer.sv
hdl/hex_seg_decoder.sv
hdl/spi_id_reader_top.sv
tests/spi_id_reader_asserts.sv
tests/spi_id_reader_tb.sv

/* tests/spi_id_cases.txt */
// test name   id (hex)   seg_hi   seg_lo
// segment codes active low gfedcba
basic_id       e5         0000110  0010010
zero_id        00         1000000  1000000
ones_id        ff         0001110  0001110
id_12          12         1111001  0100100
id_34          34         0110000  0011001
id_67          67         0000010  1111000
id_89          89         0000000  0010000
id_ab          ab         0001000  0000011
id_cd          cd         1000110  0100001
alt_5a         5a         0010010  0001000

/* tests/spi_id_reader_tb.sv */
`timescale 1ns/10ps
`include "spi_id_cfg.svh"

module spi_id_reader_tb
  import spi_id_pkg::*;
();

  localparam int          MAX_CASES = 16;
  localparam logic [23:0] EXP_MOSI  = 24'h0B_00_00;   // Read command, ID address, dummy

  logic      i_Clk;
  logic      i_Rst_L;
  logic      i_start;
  logic      i_spi_miso;
  spi_pins_t o_spi;
  byte_t     o_dev_id;
  logic      o_id_valid;
  seg7_t     o_seg_hi;
  seg7_t     o_seg_lo;

  string names[MAX_CASES];
  byte_t ids[MAX_CASES];         // ID the target returns
  seg7_t exp_hi[MAX_CASES];
  seg7_t exp_lo[MAX_CASES];
  byte_t rnd_cmd[MAX_CASES];     // Target reply during the command byte
  byte_t rnd_addr[MAX_CASES];    // Target reply during the address byte
  int    num_cases   = 0;
  int    err_cnt     = 0;
  int    cycle_cnt   = 0;
  int    cycle_limit = 100000;   // Replaced once the cases are loaded

  // SPI target model
  logic        prev_sclk = 1'b0;
  logic        prev_cs_n = 1'b1;
  logic [23:0] mosi_word = '0;
  logic [23:0] miso_word = '0;
  int          win_idx   = 0;    // Index of the open window
  int          rise_cnt  = 0;
  int          fall_cnt  = 0;
  int          hi_cnt    = 0;    // Cycles seen with CS high
  int          id_pulses = 0;

  spi_id_reader_top dut_i (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_start    (i_start),
    .i_spi_miso (i_spi_miso),
    .o_spi      (o_spi),
    .o_dev_id   (o_dev_id),
    .o_id_valid (o_id_valid),
    .o_seg_hi   (o_seg_hi),
    .o_seg_lo   (o_seg_lo)
  );

  bind spi_cs_framer spi_id_reader_asserts asserts_i (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_tx_valid (i_tx_valid),
    .i_tx_byte  (i_tx_byte),
    .i_tx_ready (o_tx_ready),
    .i_spi      (o_spi)
  );

  initial
  begin
    i_Clk = 1'b0;
    forever #10 i_Clk = ~i_Clk;   // 20 ns period
  end

  always @(posedge i_Clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("Timeout, the DUT gave no result within %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_val(input string label, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    if (exp_val !== act_val)
    begin
      $display("FAIL %0s expected 0x%0h actual 0x%0h", label, exp_val, act_val);
      err_cnt++;
    end
  endtask

  function automatic string case_name(input int idx);
    if (idx < num_cases)
      return names[idx];
    return "extra_window";   // Window with no case behind it
  endfunction

  //////////////////////////////////////////////////////////////////////
  // SPI target model sampling the pins on the system clock
  //////////////////////////////////////////////////////////////////////

  always @(posedge i_Clk)
  begin
    if (i_Rst_L)
    begin
      if (o_spi.cs_n)
        check_val({case_name(win_idx), " sclk with cs high"}, 0, o_spi.sclk);
      if (!o_spi.cs_n && prev_cs_n)   // Window opens
      begin
        if (win_idx > 0)
          check_val({case_name(win_idx), " cs gap too short"}, 1,
                    (hi_cnt >= `SPI_CS_INACTIVE_CLKS) ? 1 : 0);
        if (win_idx < num_cases)
          miso_word = {rnd_cmd[win_idx], rnd_addr[win_idx], ids[win_idx]};
        else
          miso_word = '0;
        i_spi_miso <= miso_word[23];   // MSB ahead of the first rising edge
        rise_cnt  = 0;
        fall_cnt  = 0;
        mosi_word = '0;
      end
      if (o_spi.sclk && !prev_sclk)
      begin
        rise_cnt++;
        mosi_word = {mosi_word[22:0], o_spi.mosi};
      end
      if (!o_spi.sclk && prev_sclk && !o_spi.cs_n)
      begin
        fall_cnt++;
        if (fall_cnt < 24)
          i_spi_miso <= miso_word[23 - fall_cnt];   // Next bit after the falling edge
      end
      if (o_spi.cs_n && !prev_cs_n)   // Window closes
      begin
        check_val({case_name(win_idx), " sclk rising edges"}, 24, rise_cnt);
        check_val({case_name(win_idx), " mosi bytes"}, EXP_MOSI, mosi_word);
        hi_cnt = 0;
        win_idx++;
      end
      if (o_spi.cs_n)
        hi_cnt++;
      if (o_id_valid)
        id_pulses++;
    end
    prev_sclk = o_spi.sclk;
    prev_cs_n = o_spi.cs_n;
  end

  task automatic load_cases(input int fd);
    logic [8*64-1:0] line_buf;
    logic [8*24-1:0] name_buf;
    logic [31:0]     rnd_val;
    byte_t           id_val;
    seg7_t           hi_val;
    seg7_t           lo_val;
    int              code;
    while (!$feof(fd) && num_cases < MAX_CASES)
    begin
      line_buf = '0;
      code = $fgets(line_buf, fd);
      code = $sscanf(line_buf, "%s %h %b %b", name_buf, id_val, hi_val, lo_val);
      if (code == 4)   // Comment and blank lines fall through
      begin
        names[num_cases]  = $sformatf("%0s", name_buf);
        ids[num_cases]    = id_val;
        exp_hi[num_cases] = hi_val;
        exp_lo[num_cases] = lo_val;
        rnd_val = $urandom;
        rnd_cmd[num_cases] = rnd_val[7:0];
        rnd_val = $urandom;
        rnd_addr[num_cases] = rnd_val[7:0];
        num_cases++;
      end
    end
    $fclose(fd);
    cycle_limit = (num_cases + 1) * 300 + 16;
  endtask

  //////////////////////////////////////////////////////////////////////
  // One single read followed by back-to-back reads
  //////////////////////////////////////////////////////////////////////

  task automatic run_cases();
    int err_start;
    int n_pass;
    int i;
    n_pass = 0;
    check_val("cases loaded", 1, (num_cases > 0) ? 1 : 0);
    repeat (16) @(posedge i_Clk);
    i_Rst_L <= 1'b1;
    for (i = 0; i < num_cases; i++)
    begin
      err_start = err_cnt;
      @(posedge i_Clk);
      if (i < 2)
        i_start <= 1'b1;
      @(posedge i_Clk);
      if (i == 0)
        i_start <= 1'b0;   // Single cycle request
      while (!o_id_valid)
        @(posedge i_Clk);
      check_val({names[i], " dev_id"}, ids[i], o_dev_id);
      check_val({names[i], " seg_hi"}, exp_hi[i], o_seg_hi);
      check_val({names[i], " seg_lo"}, exp_lo[i], o_seg_lo);
      if (i == num_cases - 1)
        i_start <= 1'b0;   // No further read after the last
      while (win_idx <= i)
        @(posedge i_Clk);
      if (err_cnt == err_start)
      begin
        $display("test %0s passed, id 0x%02h", names[i], ids[i]);
        n_pass++;
      end
      else
        $display("test %0s failed, id 0x%02h", names[i], ids[i]);
    end
    repeat (50) @(posedge i_Clk);   // Room for a stray extra read
    check_val("id_valid pulses", num_cases, id_pulses);
    check_val("cs windows", num_cases, win_idx);
    check_val("assertion failures", 0, dut_i.framer_i.asserts_i.fail_cnt);
    $display("%0d tests, %0d passed, %0d checks failed", num_cases, n_pass, err_cnt);
    if (err_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  endtask

  initial
  begin
    int fd;
    i_Rst_L    = 1'b0;
    i_start    = 1'b0;
    i_spi_miso = 1'b0;
    void'($urandom(69));
    fd = $fopen("tests/spi_id_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the cases file tests/spi_id_cases.txt");
      $display("Something failed");
      $finish;
    end
    else
    begin
      load_cases(fd);
      run_cases();
    end
  end

endmodule

/* tests/spi_id_reader_asserts.sv */
`timescale 1ns/10ps
`include "spi_id_cfg.svh"

module spi_id_reader_asserts
  import spi_id_pkg::*;
(
  input logic      i_Clk,
  input logic      i_Rst_L,
  input logic      i_tx_valid,   // Byte request channel into the framer
  input byte_t     i_tx_byte,
  input logic      i_tx_ready,
  input spi_pins_t i_spi
);

  int fail_cnt = 0;   // Failed assertions so far

  //////////////////////////////////////////////////////////////////////
  // SPI pins
  //////////////////////////////////////////////////////////////////////

  // Mode 0 clock stays parked while the target is deselected
  a_sclk_idle: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_spi.cs_n |-> !i_spi.sclk)
  else
  begin
    $error("SCLK high while CS is high");
    fail_cnt++;
  end

  // Minimum deselect time after each burst
  a_cs_gap: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    $rose(i_spi.cs_n) |-> i_spi.cs_n [*`SPI_CS_INACTIVE_CLKS])
  else
  begin
    $error("CS high for fewer than %0d cycles", `SPI_CS_INACTIVE_CLKS);
    fail_cnt++;
  end

  //////////////////////////////////////////////////////////////////////
  // Byte request handshake
  //////////////////////////////////////////////////////////////////////

  a_valid_hold: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_byte)))
  else
  begin
    $error("Request dropped or changed before ready");
    fail_cnt++;
  end

endmodule

/* hdl/spi_id_reader_top.sv */
`timescale 1ns/10ps

module spi_id_reader_top
  import spi_id_pkg::*;
(
  input  logic      i_Clk,
  input  logic      i_Rst_L,
  input  logic      i_start,
  input  logic      i_spi_miso,
  output spi_pins_t o_spi,
  output byte_t     o_dev_id,
  output logic      o_id_valid,
  output seg7_t     o_seg_hi,
  output seg7_t     o_seg_lo
);

  logic       w_tx_valid;   // Byte request channel
  byte_t      w_tx_byte;
  burst_cnt_t w_burst_len;
  logic       w_tx_ready;
  logic       w_rx_valid;   // Receive path, no back-pressure
  byte_t      w_rx_byte;

  devid_sequencer seq_i (
    .i_Clk       (i_Clk),
    .i_Rst_L     (i_Rst_L),
    .i_start     (i_start),
    .o_tx_valid  (w_tx_valid),
    .o_tx_byte   (w_tx_byte),
    .o_burst_len (w_burst_len),
    .i_tx_ready  (w_tx_ready),
    .i_rx_valid  (w_rx_valid),
    .i_rx_byte   (w_rx_byte),
    .o_dev_id    (o_dev_id),
    .o_id_valid  (o_id_valid)
  );

  spi_cs_framer framer_i (
    .i_Clk       (i_Clk),
    .i_Rst_L     (i_Rst_L),
    .i_tx_valid  (w_tx_valid),
    .i_tx_byte   (w_tx_byte),
    .i_burst_len (w_burst_len),
    .o_tx_ready  (w_tx_ready),
    .o_rx_valid  (w_rx_valid),
    .o_rx_byte   (w_rx_byte),
    .o_spi       (o_spi),
    .i_miso      (i_spi_miso)
  );

  // Two digits from the stored ID
  hex_seg_decoder seg_hi_i (.i_nibble(o_dev_id[7:4]), .o_seg(o_seg_hi));
  hex_seg_decoder seg_lo_i (.i_nibble(o_dev_id[3:0]), .o_seg(o_seg_lo));

endmodule

/* hdl/hex_seg_decoder.sv */
`timescale 1ns/10ps

module hex_seg_decoder
  import spi_id_pkg::*;
(
  input  logic [3:0] i_nibble,
  output seg7_t      o_seg      // Low lights a segment
);

  always_comb
  begin
    case (i_nibble)       //   gfedcba
      4'h0:    o_seg = 7'b1000000;
      4'h1:    o_seg = 7'b1111001;
      4'h2:    o_seg = 7'b0100100;
      4'h3:    o_seg = 7'b0110000;
      4'h4:    o_seg = 7'b0011001;
      4'h5:    o_seg = 7'b0010010;
      4'h6:    o_seg = 7'b0000010;
      4'h7:    o_seg = 7'b1111000;
      4'h8:    o_seg = 7'b0000000;
      4'h9:    o_seg = 7'b0010000;
      4'hA:    o_seg = 7'b0001000;
      4'hB:    o_seg = 7'b0000011;   // Lower case b
      4'hC:    o_seg = 7'b1000110;
      4'hD:    o_seg = 7'b0100001;   // Lower case d
      4'hE:    o_seg = 7'b0000110;
      default: o_seg = 7'b0001110;   // F
    endcase
  end

endmodule

/* hdl/devid_sequencer.sv */
`timescale 1ns/10ps
`include "spi_id_cfg.svh"

module devid_sequencer
  import spi_id_pkg::*;
(
  input  logic       i_Clk,
  input  logic       i_Rst_L,
  input  logic       i_start,      // Level, sampled in idle only
  output logic       o_tx_valid,
  output byte_t      o_tx_byte,
  output burst_cnt_t o_burst_len,
  input  logic       i_tx_ready,
  input  logic       i_rx_valid,
  input  byte_t      i_rx_byte,
  output byte_t      o_dev_id,
  output logic       o_id_valid    // One-cycle pulse per read
);

  seq_state_t r_state;
  burst_cnt_t r_rx_cnt;   // Received bytes in this read
  logic       w_id_rx;    // The ID byte arrives now

  assign w_id_rx     = i_rx_valid & (r_rx_cnt == burst_cnt_t'(`SPI_BYTES_PER_READ - 1));
  assign o_burst_len = burst_cnt_t'(`SPI_BYTES_PER_READ);

  // Offer held until the framer takes it
  always_comb
  begin
    o_tx_valid = 1'b1;
    case (r_state)
      SEQ_SEND_CMD:   o_tx_byte = `SPI_READ_CMD;
      SEQ_SEND_ADDR:  o_tx_byte = `SPI_DEVID_ADDR;
      SEQ_SEND_DUMMY: o_tx_byte = 8'h00;   // Clocks the ID in
      default:
      begin
        o_tx_valid = 1'b0;
        o_tx_byte  = 8'h00;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Read FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      r_state <= SEQ_IDLE;
    else
    begin
      case (r_state)
        SEQ_IDLE:       if (i_start) r_state <= SEQ_SEND_CMD;
        SEQ_SEND_CMD:   if (i_tx_ready) r_state <= SEQ_SEND_ADDR;
        SEQ_SEND_ADDR:  if (i_tx_ready) r_state <= SEQ_SEND_DUMMY;
        SEQ_SEND_DUMMY: if (i_tx_ready) r_state <= SEQ_WAIT_RX;
        SEQ_WAIT_RX:    if (w_id_rx) r_state <= SEQ_WAIT_DONE;
        SEQ_WAIT_DONE:  if (i_tx_ready) r_state <= SEQ_IDLE;   // Gap over
        default:        r_state <= SEQ_IDLE;
      endcase
    end
  end

  // Count receive pulses and keep the third byte
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_rx_cnt   <= '0;
      o_dev_id   <= 8'h00;
      o_id_valid <= 1'b0;
    end
    else
    begin
      o_id_valid <= 1'b0;
      if (r_state == SEQ_IDLE)
        r_rx_cnt <= '0;
      else if (i_rx_valid)
        r_rx_cnt <= r_rx_cnt + 1'b1;
      if (w_id_rx)
      begin
        o_dev_id   <= i_rx_byte;
        o_id_valid <= 1'b1;
      end
    end
  end

endmodule

/* hdl/spi_cs_framer.sv */
`timescale 1ns/10ps
`include "spi_id_cfg.svh"

module spi_cs_framer
  import spi_id_pkg::*;
(
  input  logic       i_Clk,
  input  logic       i_Rst_L,
  input  logic       i_tx_valid,
  input  byte_t      i_tx_byte,
  input  burst_cnt_t i_burst_len,   // Sampled with the first byte only
  output logic       o_tx_ready,
  output logic       o_rx_valid,
  output byte_t      o_rx_byte,
  output spi_pins_t  o_spi,
  input  logic       i_miso
);

  localparam int GAP_W = $clog2(`SPI_CS_INACTIVE_CLKS + 1);

  cs_state_t        r_state;
  logic             r_cs_n;
  burst_cnt_t       r_bytes_left;   // Bytes still to come after the current one
  logic [GAP_W-1:0] r_gap_cnt;
  logic             w_accept;       // Byte handed to the engine this cycle
  logic             w_eng_ready;
  logic             w_sclk;
  logic             w_mosi;

  assign w_accept   = i_tx_valid & o_tx_ready;
  assign o_tx_ready = (r_state == CS_IDLE) |
                      ((r_state == CS_TRANSFER) & w_eng_ready & (r_bytes_left != '0));

  spi_byte_engine engine_i (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_tx_start (w_accept),
    .i_tx_byte  (i_tx_byte),
    .o_ready    (w_eng_ready),
    .o_rx_valid (o_rx_valid),   // Receive path goes straight up
    .o_rx_byte  (o_rx_byte),
    .o_sclk     (w_sclk),
    .o_mosi     (w_mosi),
    .i_miso     (i_miso)
  );

  //////////////////////////////////////////////////////////////////////
  // CS framing FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state      <= CS_IDLE;
      r_cs_n       <= 1'b1;
      r_bytes_left <= '0;
      r_gap_cnt    <= '0;
    end
    else
    begin
      case (r_state)
        CS_IDLE:
        begin
          if (w_accept)
          begin
            r_bytes_left <= i_burst_len - 1'b1;   // First byte already taken
            r_cs_n       <= 1'b0;
            r_state      <= CS_TRANSFER;
          end
        end
        CS_TRANSFER:
        begin
          if (w_eng_ready)
          begin
            if (r_bytes_left != '0)
            begin
              if (i_tx_valid)
                r_bytes_left <= r_bytes_left - 1'b1;
            end
            else
            begin
              r_cs_n    <= 1'b1;                                // Burst finished
              r_gap_cnt <= GAP_W'(`SPI_CS_INACTIVE_CLKS - 1);
              r_state   <= CS_GAP;
            end
          end
        end
        CS_GAP:
        begin
          if (r_gap_cnt != '0)
            r_gap_cnt <= r_gap_cnt - 1'b1;
          else
            r_state <= CS_IDLE;
        end
        default:
        begin
          r_cs_n  <= 1'b1;
          r_state <= CS_IDLE;
        end
      endcase
    end
  end

  assign o_spi.sclk = w_sclk;
  assign o_spi.mosi = w_mosi;
  assign o_spi.cs_n = r_cs_n;

endmodule

/* hdl/spi_byte_engine.sv */
`timescale 1ns/10ps
`include "spi_id_cfg.svh"

module spi_byte_engine
  import spi_id_pkg::*;
(
  input  logic  i_Clk,
  input  logic  i_Rst_L,
  input  logic  i_tx_start,   // One-cycle pulse with i_tx_byte
  input  byte_t i_tx_byte,
  output logic  o_ready,      // High while idle
  output logic  o_rx_valid,   // One-cycle pulse with o_rx_byte
  output byte_t o_rx_byte,
  output logic  o_sclk,
  output logic  o_mosi,
  input  logic  i_miso
);

  localparam int HALF_BIT = `SPI_CLKS_PER_HALF_BIT;
  localparam int CNT_W    = $clog2(HALF_BIT * 2);

  logic [CNT_W-1:0] r_clk_cnt;   // Position inside one SCLK period
  logic [4:0]       r_edges;     // SCLK edges still to make
  logic             r_sclk;      // Internal SCLK, one cycle ahead of the pin
  logic             r_lead;      // Rising edge strobe
  logic             r_trail;     // Falling edge strobe
  logic             r_tx_start;  // Start delayed to align with the byte register
  byte_t            r_tx_byte;
  logic [2:0]       r_tx_bit;
  logic [2:0]       r_rx_bit;

  //////////////////////////////////////////////////////////////////////
  // SCLK generation, 16 edges per byte
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_ready   <= 1'b1;
      r_edges   <= '0;
      r_lead    <= 1'b0;
      r_trail   <= 1'b0;
      r_sclk    <= 1'b0;   // Mode 0 idles low
      r_clk_cnt <= '0;
    end
    else
    begin
      r_lead  <= 1'b0;   // Strobes last one cycle
      r_trail <= 1'b0;
      if (i_tx_start)
      begin
        o_ready <= 1'b0;
        r_edges <= 5'd16;
      end
      else if (r_edges != '0)
      begin
        o_ready <= 1'b0;
        if (r_clk_cnt == CNT_W'(HALF_BIT * 2 - 1))
        begin
          r_edges   <= r_edges - 5'd1;
          r_trail   <= 1'b1;              // Falling edge
          r_clk_cnt <= '0;
          r_sclk    <= ~r_sclk;
        end
        else if (r_clk_cnt == CNT_W'(HALF_BIT - 1))
        begin
          r_edges   <= r_edges - 5'd1;
          r_lead    <= 1'b1;              // Rising edge
          r_clk_cnt <= r_clk_cnt + 1'b1;
          r_sclk    <= ~r_sclk;
        end
        else
          r_clk_cnt <= r_clk_cnt + 1'b1;
      end
      else
        o_ready <= 1'b1;   // Last edge done
    end
  end

  // Byte is held locally, the caller may change it after start
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      r_tx_start <= 1'b0;
    else
      r_tx_start <= i_tx_start;
  end

  always_ff @(posedge i_Clk)
  begin
    if (i_tx_start)
      r_tx_byte <= i_tx_byte;
  end

  //////////////////////////////////////////////////////////////////////
  // MOSI out, MSB first, shifted on falling edges
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_mosi   <= 1'b0;
      r_tx_bit <= 3'd7;
    end
    else if (o_ready)
      r_tx_bit <= 3'd7;
    else if (r_tx_start)
    begin
      o_mosi   <= r_tx_byte[7];   // First bit ahead of the first rising edge
      r_tx_bit <= 3'd6;
    end
    else if (r_trail)
    begin
      o_mosi   <= r_tx_byte[r_tx_bit];
      r_tx_bit <= r_tx_bit - 3'd1;
    end
  end

  // MISO sampled on rising edges
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_rx_valid <= 1'b0;
      r_rx_bit   <= 3'd7;
    end
    else
    begin
      o_rx_valid <= 1'b0;
      if (o_ready)
        r_rx_bit <= 3'd7;
      else if (r_lead)
      begin
        r_rx_bit <= r_rx_bit - 3'd1;
        if (r_rx_bit == 3'd0)
          o_rx_valid <= 1'b1;   // Eighth sample completes the byte
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (r_lead)
      o_rx_byte[r_rx_bit] <= i_miso;
  end

  // One register of delay lines SCLK up with MOSI
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_sclk <= 1'b0;
    else
      o_sclk <= r_sclk;
  end

endmodule

/* hdl/spi_id_pkg.sv */
`include "spi_id_cfg.svh"

package spi_id_pkg;

  // SPI pins driven by the controller
  typedef struct packed {
    logic sclk;   // Mode 0, idles low
    logic mosi;
    logic cs_n;   // Active low select
  } spi_pins_t;

  typedef logic [7:0] byte_t;

  typedef logic [6:0] seg7_t;   // Active low, bit 0 is segment a

  // Holds 0 up to the full burst length
  typedef logic [$clog2(`SPI_BYTES_PER_READ + 1)-1:0] burst_cnt_t;

  // Chip-select framer states
  typedef enum logic [1:0] {
    CS_IDLE,
    CS_TRANSFER,
    CS_GAP          // CS high, next burst held off
  } cs_state_t;

  // Device ID sequencer states
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_SEND_CMD,
    SEQ_SEND_ADDR,
    SEQ_SEND_DUMMY,
    SEQ_WAIT_RX,    // Waiting for the ID byte
    SEQ_WAIT_DONE   // Waiting for the framer gap to end
  } seq_state_t;

endpackage

/* hdl/spi_id_cfg.svh */
`ifndef SPI_ID_CFG_SVH
`define SPI_ID_CFG_SVH

//////////////////////////////////////////////////////////////////////
// SPI link timing
//////////////////////////////////////////////////////////////////////

`define SPI_CLKS_PER_HALF_BIT 2   // System clocks per SCLK half period
`define SPI_CS_INACTIVE_CLKS  2   // Minimum CS high time after a burst

//////////////////////////////////////////////////////////////////////
// Device ID read transaction
//////////////////////////////////////////////////////////////////////

`define SPI_BYTES_PER_READ 3        // Command, address, dummy
`define SPI_READ_CMD       8'h0B    // Register read opcode
`define SPI_DEVID_ADDR     8'h00    // Device ID register

`endif
